// File: gpuCorePkg.sv
package gpuCorePkg;

    localparam int wordWidth = 32; // data and instruction width
    localparam int regAddrWidth = 3; // eight registers
    localparam int threadReg = 7; // loaded with threadId during reset

    typedef enum logic [3:0] {
        opAdd      = 4'd0, // add or subtract
        opBitwise  = 4'd1, // and / or
        opShift    = 4'd3,
        opCmpImm   = 4'd4,
        opCmpReg   = 4'd5,
        opLoadImm  = 4'd10,
        opLoadReg  = 4'd11,
        opStoreImm = 4'd14,
        opStoreReg = 4'd15
    } opcode_t; // 2, 8, 9, 12, 13 decode as no-ops

    typedef enum logic [4:0] {
        Decode, // idle, waiting for an instruction
        Alu1, Alu2,
        Shift1, Shift2,
        Bitwise1, Bitwise2,
        CmpImm1, CmpImm2,
        CmpReg1, CmpReg2,
        LoadImm1, LoadImm2,
        LoadReg1, LoadReg2,
        ReadMem, // wait for finishedRead
        WriteBack, // mdr into the register file
        StoreImm1, StoreImm2,
        StoreReg1, StoreReg2,
        StoreData, // store data into mdr
        WriteMem // wait for finishedWrite
    } coreState_t;

    typedef enum logic [2:0] {
        busNone, busAdd, busBitwise, busShift, busMemData, busSr1
    } busSel_t;

    // shift code is {immFlag, subFlag, sr2[2:1]}, bitwise sign bit is sr2[2]
    typedef struct packed {
        opcode_t opcode; // 31:28
        logic [2:0] dr; // 27:25
        logic [2:0] sr1; // 24:22
        logic immFlag; // 21, or-select for bitwise
        logic subFlag; // 20, immediate select for bitwise
        logic [2:0] sr2; // 19:17
        logic pad16; // 16
        logic [15:0] imm16; // 15:0
    } aluFields_t;

    typedef struct packed {
        opcode_t opcode;
        logic noPos; // 27
        logic noZero; // 26
        logic noNeg; // 25
        logic [5:0] skipCount; // 24:19
        logic [2:0] sr1; // 18:16
        logic [15:0] imm16; // sr2 shares the top three bits
    } cmpFields_t;

    typedef struct packed {
        opcode_t opcode;
        logic [2:0] dataReg; // 27:25, load target or store source
        logic [2:0] base; // 24:22
        logic [21:0] loadOffset; // sr2 at 21:19, storeOffset at 17:0
    } memFields_t;

    typedef union packed {
        aluFields_t alu;
        cmpFields_t cmp;
        memFields_t mem;
    } instrWord_t;

endpackage

// File: coreDecoder.sv
`timescale 1ns/1ps

module coreDecoder (
    input logic clk,
    input logic reset,
    input logic [gpuCorePkg::wordWidth-1:0] instruction,
    input logic executeInstruction,
    input logic finishedRead,
    input logic finishedWrite,
    input logic skipLines, // compare result, valid in CmpImm2 / CmpReg2
    output gpuCorePkg::coreState_t state,
    output gpuCorePkg::instrWord_t ir,
    output logic [gpuCorePkg::regAddrWidth-1:0] sr1Sel,
    output logic [gpuCorePkg::regAddrWidth-1:0] sr2Sel,
    output logic [gpuCorePkg::regAddrWidth-1:0] drSel,
    output logic loadReg,
    output gpuCorePkg::busSel_t busSel,
    output logic loadMar,
    output logic loadMdr,
    output logic mdrFromMem,
    output logic reading,
    output logic writing,
    output logic ready
);
    gpuCorePkg::instrWord_t newInstr; // incoming word, field view
    gpuCorePkg::coreState_t firstState; // entry state for the incoming opcode
    logic [5:0] countdown; // accepted instructions left to discard
    logic accept; // handshake on this edge

    assign newInstr = instruction;
    assign ready = (state == gpuCorePkg::Decode);
    assign accept = ready && executeInstruction;

    always_comb begin
        case (newInstr.alu.opcode)
            gpuCorePkg::opAdd: firstState = gpuCorePkg::Alu1;
            gpuCorePkg::opBitwise: firstState = gpuCorePkg::Bitwise1;
            gpuCorePkg::opShift: firstState = gpuCorePkg::Shift1;
            gpuCorePkg::opCmpImm: firstState = gpuCorePkg::CmpImm1;
            gpuCorePkg::opCmpReg: firstState = gpuCorePkg::CmpReg1;
            gpuCorePkg::opLoadImm: firstState = gpuCorePkg::LoadImm1;
            gpuCorePkg::opLoadReg: firstState = gpuCorePkg::LoadReg1;
            gpuCorePkg::opStoreImm: firstState = gpuCorePkg::StoreImm1;
            gpuCorePkg::opStoreReg: firstState = gpuCorePkg::StoreReg1;
            default: firstState = gpuCorePkg::Decode; // multiply and scratchpad ops
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= gpuCorePkg::Decode;
            countdown <= '0;
        end else begin
            if (accept && countdown == 0) begin
                ir <= newInstr; // latched even for no-op opcodes
                state <= firstState;
            end else begin
                case (state)
                    gpuCorePkg::Alu1: state <= gpuCorePkg::Alu2;
                    gpuCorePkg::Shift1: state <= gpuCorePkg::Shift2;
                    gpuCorePkg::Bitwise1: state <= gpuCorePkg::Bitwise2;
                    gpuCorePkg::CmpImm1: state <= gpuCorePkg::CmpImm2;
                    gpuCorePkg::CmpReg1: state <= gpuCorePkg::CmpReg2;
                    gpuCorePkg::LoadImm1: state <= gpuCorePkg::LoadImm2;
                    gpuCorePkg::LoadReg1: state <= gpuCorePkg::LoadReg2;
                    gpuCorePkg::LoadImm2,
                    gpuCorePkg::LoadReg2: state <= gpuCorePkg::ReadMem; // mar loaded here
                    gpuCorePkg::ReadMem:
                        state <= finishedRead ? gpuCorePkg::WriteBack : gpuCorePkg::ReadMem;
                    gpuCorePkg::StoreImm1: state <= gpuCorePkg::StoreImm2;
                    gpuCorePkg::StoreReg1: state <= gpuCorePkg::StoreReg2;
                    gpuCorePkg::StoreImm2,
                    gpuCorePkg::StoreReg2: state <= gpuCorePkg::StoreData;
                    gpuCorePkg::StoreData: state <= gpuCorePkg::WriteMem;
                    gpuCorePkg::WriteMem:
                        state <= finishedWrite ? gpuCorePkg::Decode : gpuCorePkg::WriteMem;
                    default: state <= gpuCorePkg::Decode; // last cycle of alu, compare, load
                endcase
            end

            if (skipLines && (state == gpuCorePkg::CmpImm2 || state == gpuCorePkg::CmpReg2)) begin
                countdown <= ir.cmp.skipCount; // compare true, start skipping
            end else if (accept && countdown != 0) begin
                countdown <= countdown - 1'b1; // instruction discarded
            end
        end
    end

    always_comb begin
        sr1Sel = ir.alu.sr1; // alu view unless the state says otherwise
        sr2Sel = ir.alu.sr2;
        drSel = ir.alu.dr;
        loadReg = 1'b0;
        busSel = gpuCorePkg::busNone;
        loadMar = 1'b0;
        loadMdr = 1'b0;
        mdrFromMem = 1'b0;
        reading = 1'b0;
        writing = 1'b0;
        case (state)
            gpuCorePkg::CmpImm1, gpuCorePkg::CmpReg1: begin
                sr1Sel = ir.cmp.sr1;
                sr2Sel = ir.cmp.imm16[15:13]; // sr2 of the compare view
            end
            gpuCorePkg::Alu2: begin
                loadReg = 1'b1;
                busSel = gpuCorePkg::busAdd;
            end
            gpuCorePkg::Shift2: begin
                loadReg = 1'b1;
                busSel = gpuCorePkg::busShift;
            end
            gpuCorePkg::Bitwise2: begin
                loadReg = 1'b1;
                busSel = gpuCorePkg::busBitwise;
            end
            gpuCorePkg::LoadImm1, gpuCorePkg::LoadReg1,
            gpuCorePkg::StoreImm1, gpuCorePkg::StoreReg1: begin
                sr1Sel = ir.mem.base;
                sr2Sel = ir.mem.loadOffset[21:19]; // register offset
            end
            gpuCorePkg::LoadImm2, gpuCorePkg::LoadReg2: begin
                loadMar = 1'b1; // address from the adder
                busSel = gpuCorePkg::busAdd;
            end
            gpuCorePkg::StoreImm2, gpuCorePkg::StoreReg2: begin
                loadMar = 1'b1;
                busSel = gpuCorePkg::busAdd;
                sr1Sel = ir.mem.dataReg; // fetch the store data
            end
            gpuCorePkg::ReadMem: begin
                reading = 1'b1;
                mdrFromMem = 1'b1;
                loadMdr = finishedRead; // capture on the finishing edge
            end
            gpuCorePkg::WriteBack: begin
                loadReg = 1'b1;
                busSel = gpuCorePkg::busMemData;
                drSel = ir.mem.dataReg;
            end
            gpuCorePkg::StoreData: begin
                loadMdr = 1'b1;
                busSel = gpuCorePkg::busSr1;
            end
            gpuCorePkg::WriteMem: writing = 1'b1;
            default: ;
        endcase
    end

endmodule

// File: registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input logic clk,
    input logic reset,
    input logic [gpuCorePkg::wordWidth-1:0] threadId,
    input logic [gpuCorePkg::regAddrWidth-1:0] sr1Sel,
    input logic [gpuCorePkg::regAddrWidth-1:0] sr2Sel,
    input logic [gpuCorePkg::regAddrWidth-1:0] drSel,
    input logic loadReg,
    input logic [gpuCorePkg::wordWidth-1:0] resultBus,
    output logic [gpuCorePkg::wordWidth-1:0] sr1Data,
    output logic [gpuCorePkg::wordWidth-1:0] sr2Data
);
    logic [gpuCorePkg::wordWidth-1:0] regs [2**gpuCorePkg::regAddrWidth];

    always_ff @(posedge clk) begin
        sr1Data <= regs[sr1Sel]; // one cycle read latency
        sr2Data <= regs[sr2Sel];
        if (reset) begin
            regs[gpuCorePkg::threadReg] <= threadId; // thread index preset
        end else if (loadReg) begin
            regs[drSel] <= resultBus;
        end
    end

endmodule

// File: aluExecute.sv
`timescale 1ns/1ps

module aluExecute (
    input gpuCorePkg::coreState_t state,
    input gpuCorePkg::instrWord_t ir,
    input logic [gpuCorePkg::wordWidth-1:0] sr1Data,
    input logic [gpuCorePkg::wordWidth-1:0] sr2Data,
    output logic [gpuCorePkg::wordWidth-1:0] addResult,
    output logic [gpuCorePkg::wordWidth-1:0] bitwiseResult,
    output logic [gpuCorePkg::wordWidth-1:0] shiftResult,
    output logic skipLines
);
    logic [gpuCorePkg::wordWidth-1:0] addIn2; // second adder operand
    logic [gpuCorePkg::wordWidth-1:0] bitwiseIn2;
    logic [gpuCorePkg::wordWidth-1:0] cmpIn2;
    logic [gpuCorePkg::wordWidth-1:0] cmpDiff;
    logic [3:0] shiftCode; // instruction bits 21:18
    logic [4:0] shiftAmt;
    logic cmpNeg, cmpZero, cmpPos;

    always_comb begin
        case (state)
            gpuCorePkg::Alu2: // zero-extended immediate for arithmetic
                addIn2 = ir.alu.immFlag ? {16'h0000, ir.alu.imm16} : sr2Data;
            gpuCorePkg::LoadImm2:
                addIn2 = {{10{ir.mem.loadOffset[21]}}, ir.mem.loadOffset};
            gpuCorePkg::StoreImm2:
                addIn2 = {{14{ir.mem.loadOffset[17]}}, ir.mem.loadOffset[17:0]};
            default: addIn2 = sr2Data; // register offsets
        endcase
        if (state == gpuCorePkg::Alu2 && ir.alu.subFlag) begin
            addResult = sr1Data - addIn2;
        end else begin
            addResult = sr1Data + addIn2;
        end
    end

    // bitwise reuses bit 20 as immediate select and bit 21 as or-select
    assign bitwiseIn2 = ir.alu.subFlag ? {{16{ir.alu.sr2[2]}}, ir.alu.imm16} : sr2Data;
    assign bitwiseResult = ir.alu.immFlag ? (sr1Data | bitwiseIn2) : (sr1Data & bitwiseIn2);

    assign shiftCode = {ir.alu.immFlag, ir.alu.subFlag, ir.alu.sr2[2:1]};

    always_comb begin
        case (shiftCode[2:0])
            3'd0: shiftAmt = 5'd1;
            3'd1: shiftAmt = 5'd2;
            3'd2: shiftAmt = 5'd4;
            3'd3: shiftAmt = 5'd8;
            3'd4: shiftAmt = 5'd16;
            3'd5: shiftAmt = 5'd24;
            default: shiftAmt = 5'd0; // pass-through codes
        endcase
        shiftResult = shiftCode[3] ? (sr1Data << shiftAmt) : (sr1Data >> shiftAmt);
    end

    always_comb begin
        if (state == gpuCorePkg::CmpReg2) begin
            cmpIn2 = sr2Data;
        end else begin
            cmpIn2 = {{16{ir.cmp.imm16[15]}}, ir.cmp.imm16}; // sign-extended
        end
        cmpDiff = sr1Data - cmpIn2;
        cmpNeg = cmpDiff[gpuCorePkg::wordWidth-1];
        cmpZero = (cmpDiff == '0);
        cmpPos = !cmpNeg && !cmpZero;
        // skip when the result class is not masked off
        skipLines = (cmpNeg && !ir.cmp.noNeg) || (cmpZero && !ir.cmp.noZero)
            || (cmpPos && !ir.cmp.noPos);
    end

endmodule

// File: resultPath.sv
`timescale 1ns/1ps

module resultPath (
    input logic clk,
    input logic reset,
    input gpuCorePkg::busSel_t busSel,
    input logic loadMar,
    input logic loadMdr,
    input logic mdrFromMem, // mdr source is the memory port
    input logic [gpuCorePkg::wordWidth-1:0] addResult,
    input logic [gpuCorePkg::wordWidth-1:0] bitwiseResult,
    input logic [gpuCorePkg::wordWidth-1:0] shiftResult,
    input logic [gpuCorePkg::wordWidth-1:0] sr1Data,
    input logic [gpuCorePkg::wordWidth-1:0] memReadData,
    output logic [gpuCorePkg::wordWidth-1:0] resultBus,
    output logic [gpuCorePkg::wordWidth-1:0] marOut,
    output logic [gpuCorePkg::wordWidth-1:0] mdrOut
);
    logic [gpuCorePkg::wordWidth-1:0] mar; // memory address
    logic [gpuCorePkg::wordWidth-1:0] mdr; // memory data, both directions

    always_comb begin
        case (busSel)
            gpuCorePkg::busAdd: resultBus = addResult;
            gpuCorePkg::busBitwise: resultBus = bitwiseResult;
            gpuCorePkg::busShift: resultBus = shiftResult;
            gpuCorePkg::busMemData: resultBus = mdr; // load write-back
            gpuCorePkg::busSr1: resultBus = sr1Data; // store data
            default: resultBus = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mar <= '0;
            mdr <= '0;
        end else begin
            if (loadMar) begin
                mar <= resultBus;
            end
            if (loadMdr) begin
                mdr <= mdrFromMem ? memReadData : resultBus;
            end
        end
    end

    assign marOut = mar;
    assign mdrOut = mdr;

endmodule

// File: gpuCore.sv
`timescale 1ns/1ps

module gpuCore (
    input logic clk,
    input logic reset,
    input logic [gpuCorePkg::wordWidth-1:0] instruction,
    input logic executeInstruction, // instruction valid
    input logic [gpuCorePkg::wordWidth-1:0] threadId,
    input logic finishedRead,
    input logic finishedWrite,
    input logic [gpuCorePkg::wordWidth-1:0] memReadData,
    output logic ready, // core in Decode
    output logic reading,
    output logic writing,
    output logic [gpuCorePkg::wordWidth-1:0] marOut,
    output logic [gpuCorePkg::wordWidth-1:0] mdrOut
);
    gpuCorePkg::coreState_t state;
    gpuCorePkg::instrWord_t ir;
    gpuCorePkg::busSel_t busSel;
    logic [gpuCorePkg::regAddrWidth-1:0] sr1Sel, sr2Sel, drSel;
    logic loadReg, loadMar, loadMdr, mdrFromMem, skipLines;
    logic [gpuCorePkg::wordWidth-1:0] sr1Data, sr2Data, resultBus;
    logic [gpuCorePkg::wordWidth-1:0] addResult, bitwiseResult, shiftResult;

    coreDecoder u_coreDecoder (
        .clk(clk),
        .reset(reset),
        .instruction(instruction),
        .executeInstruction(executeInstruction),
        .finishedRead(finishedRead),
        .finishedWrite(finishedWrite),
        .skipLines(skipLines),
        .state(state),
        .ir(ir),
        .sr1Sel(sr1Sel),
        .sr2Sel(sr2Sel),
        .drSel(drSel),
        .loadReg(loadReg),
        .busSel(busSel),
        .loadMar(loadMar),
        .loadMdr(loadMdr),
        .mdrFromMem(mdrFromMem),
        .reading(reading),
        .writing(writing),
        .ready(ready)
    );

    registerFile u_registerFile (
        .clk(clk),
        .reset(reset),
        .threadId(threadId),
        .sr1Sel(sr1Sel),
        .sr2Sel(sr2Sel),
        .drSel(drSel),
        .loadReg(loadReg),
        .resultBus(resultBus),
        .sr1Data(sr1Data),
        .sr2Data(sr2Data)
    );

    aluExecute u_aluExecute (
        .state(state),
        .ir(ir),
        .sr1Data(sr1Data),
        .sr2Data(sr2Data),
        .addResult(addResult),
        .bitwiseResult(bitwiseResult),
        .shiftResult(shiftResult),
        .skipLines(skipLines)
    );

    resultPath u_resultPath (
        .clk(clk),
        .reset(reset),
        .busSel(busSel),
        .loadMar(loadMar),
        .loadMdr(loadMdr),
        .mdrFromMem(mdrFromMem),
        .addResult(addResult),
        .bitwiseResult(bitwiseResult),
        .shiftResult(shiftResult),
        .sr1Data(sr1Data),
        .memReadData(memReadData),
        .resultBus(resultBus),
        .marOut(marOut),
        .mdrOut(mdrOut)
    );

endmodule

// File: gpuCoreTb.sv
`timescale 1ns/1ps

module gpuCoreTb;
    typedef logic [7:0][31:0] regArray_t; // model register file with the thread register at 7

    logic clk;
    logic reset;
    logic [31:0] instruction;
    logic executeInstruction;
    logic [31:0] threadId;
    logic finishedRead;
    logic finishedWrite;
    logic [31:0] memReadData;
    logic ready, reading, writing;
    logic [31:0] marOut, mdrOut;

    logic [31:0] memWords [256]; // read data indexed by marOut[7:0]
    regArray_t modelRegs; // expected register contents
    logic [5:0] modelSkip; // expected skip countdown
    logic [31:0] expAddrQ [$]; // stores not yet seen on the port
    logic [31:0] expDataQ [$];
    int respWait; // cycles left before a finish pulse or -1 when idle
    int readCycles, writeCycles; // cycles with reading or writing high
    int errorCount, checkCount, testErrors;

    gpuCore u_gpuCore (
        .clk(clk),
        .reset(reset),
        .instruction(instruction),
        .executeInstruction(executeInstruction),
        .threadId(threadId),
        .finishedRead(finishedRead),
        .finishedWrite(finishedWrite),
        .memReadData(memReadData),
        .ready(ready),
        .reading(reading),
        .writing(writing),
        .marOut(marOut),
        .mdrOut(mdrOut)
    );

    always #4 clk = ~clk; // 8 ns period

    function automatic logic [31:0] aluWord(input logic [3:0] op, input logic [2:0] dr,
            input logic [2:0] sr1, input logic immFlag, input logic subFlag,
            input logic [2:0] sr2, input logic [15:0] imm16);
        return {op, dr, sr1, immFlag, subFlag, sr2, 1'b0, imm16};
    endfunction

    function automatic logic [31:0] cmpWord(input logic [3:0] op, input logic [2:0] mask,
            input logic [5:0] skipCount, input logic [2:0] sr1, input logic [15:0] imm16);
        return {op, mask, skipCount, sr1, imm16}; // mask is noPos, noZero, noNeg
    endfunction

    function automatic logic [31:0] memOpWord(input logic [3:0] op, input logic [2:0] dataReg,
            input logic [2:0] base, input logic [21:0] offset);
        return {op, dataReg, base, offset};
    endfunction

    // next model state for one accepted instruction
    function automatic regArray_t referenceStep(input logic [31:0] word, input regArray_t regs,
            inout logic [5:0] skip, output logic isStore, output logic [31:0] storeAddr,
            output logic [31:0] storeData);
        regArray_t next;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] diff;
        logic [3:0] code;
        int amount;
        logic skipNow;
        next = regs;
        isStore = 1'b0;
        storeAddr = '0;
        storeData = '0;
        a = regs[word[24:22]]; // sr1 or base
        if (skip != 0) begin
            skip = skip - 6'd1; // discarded while skipping
            return next;
        end
        case (word[31:28])
            4'd0: begin
                b = word[21] ? {16'h0000, word[15:0]} : regs[word[19:17]];
                next[word[27:25]] = word[20] ? a - b : a + b;
            end
            4'd1: begin // bit 20 selects the immediate and bit 21 selects or
                b = word[20] ? {{16{word[19]}}, word[15:0]} : regs[word[19:17]];
                next[word[27:25]] = word[21] ? (a | b) : (a & b);
            end
            4'd3: begin
                code = word[21:18];
                amount = (code[2:0] == 3'd5) ? 24 : (code[2:0] > 3'd5) ? 0 : (1 << code[2:0]);
                next[word[27:25]] = code[3] ? (a << amount) : (a >> amount);
            end
            4'd4, 4'd5: begin
                a = regs[word[18:16]];
                b = word[28] ? regs[word[15:13]] : {{16{word[15]}}, word[15:0]};
                diff = a - b;
                if (diff[31]) skipNow = !word[25]; // negative
                else if (diff == 32'd0) skipNow = !word[26];
                else skipNow = !word[27];
                if (skipNow) skip = word[24:19];
            end
            4'd10, 4'd11: begin
                b = word[28] ? regs[word[21:19]] : {{10{word[21]}}, word[21:0]};
                diff = a + b; // load address
                next[word[27:25]] = memWords[diff[7:0]];
            end
            4'd14, 4'd15: begin
                b = word[28] ? regs[word[21:19]] : {{14{word[17]}}, word[17:0]};
                isStore = 1'b1;
                storeAddr = a + b;
                storeData = regs[word[27:25]];
            end
            default: ; // multiply and scratchpad opcodes do nothing
        endcase
        return next;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        assert (got === exp) else begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            errorCount++;
        end
    endtask

    task automatic waitReady(input string where);
        int n;
        n = 0;
        while (ready !== 1'b1 && n < 200) begin // bounded wait
            @(posedge clk);
            #1;
            n++;
        end
        assert (ready === 1'b1) else begin
            $display("timeout: the core did not return to ready %s", where);
            errorCount++;
        end
    endtask

    task automatic sendInstr(input logic [31:0] word);
        logic isStore;
        logic [31:0] storeAddr;
        logic [31:0] storeData;
        waitReady("before an instruction");
        instruction = word;
        executeInstruction = 1'b1;
        @(posedge clk); // accepting edge
        #1;
        executeInstruction = 1'b0;
        modelRegs = referenceStep(word, modelRegs, modelSkip, isStore, storeAddr, storeData);
        if (isStore) begin
            expAddrQ.push_back(storeAddr);
            expDataQ.push_back(storeData);
        end
    endtask

    task automatic finishTest(input string name);
        waitReady("at the end of a test");
        assert (expAddrQ.size() == 0) else begin
            $display("%0d expected stores never reached the memory port", expAddrQ.size());
            errorCount++;
            expAddrQ.delete();
            expDataQ.delete();
        end
        $display("test %s: %s, %0d errors", name,
            (errorCount == testErrors) ? "passed" : "failed", errorCount - testErrors);
        testErrors = errorCount;
    endtask

    // memory responder gives one finish pulse after 0 to 3 cycles
    always @(posedge clk) begin
        #1;
        if (finishedRead || finishedWrite) begin
            finishedRead = 1'b0;
            finishedWrite = 1'b0;
        end else if (!reset && (reading || writing)) begin
            if (respWait < 0) respWait = int'($urandom % 4);
            if (respWait == 0) begin
                memReadData = memWords[marOut[7:0]];
                finishedRead = reading;
                finishedWrite = writing;
                respWait = -1;
            end else begin
                respWait = respWait - 1;
            end
        end
    end

    // store checker samples mid-cycle on the finishing cycle
    always @(negedge clk) begin
        if (reading === 1'b1) readCycles++;
        if (writing === 1'b1) writeCycles++;
        if (writing === 1'b1 && finishedWrite) begin
            assert (expAddrQ.size() != 0) else begin
                $display("a store appeared on the memory port with none expected");
                errorCount++;
            end
            if (expAddrQ.size() != 0) begin
                checkValue("marOut", marOut, expAddrQ.pop_front());
                checkValue("mdrOut", mdrOut, expDataQ.pop_front());
            end
        end
    end

    initial begin
        int i;
        int readSnap;
        int writeSnap;
        logic [3:0] code;
        logic [31:0] word;
        logic [31:0] incR1;
        void'($urandom(11));
        clk = 1'b0;
        reset = 1'b1;
        instruction = '0;
        executeInstruction = 1'b0;
        threadId = 32'h0000_0040;
        finishedRead = 1'b0;
        finishedWrite = 1'b0;
        memReadData = '0;
        respWait = -1;
        readCycles = 0;
        writeCycles = 0;
        errorCount = 0;
        checkCount = 0;
        testErrors = 0;
        for (i = 0; i < 256; i++) memWords[i] = $urandom;
        modelRegs = '0;
        modelRegs[7] = threadId;
        modelSkip = '0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        checkValue("ready", 32'(ready), 32'd1);
        checkValue("reading", 32'(reading), 32'd0);
        checkValue("writing", 32'(writing), 32'd0);
        checkValue("marOut", marOut, 32'd0);
        checkValue("mdrOut", mdrOut, 32'd0);
        sendInstr(memOpWord(4'd14, 3'd7, 3'd7, 22'd0)); // r7 to address threadId
        finishTest("reset values");

        for (i = 0; i < 4; i++) begin // offsets -32 to 63 from r7
            sendInstr(memOpWord(4'd10, 3'(i), 3'd7, 22'($urandom % 96) - 22'd32));
        end
        for (i = 4; i < 7; i++) sendInstr(memOpWord(4'd11, 3'(i), 3'd7, {3'(i - 4), 19'd0}));
        for (i = 0; i < 7; i++) sendInstr(memOpWord(4'd14, 3'(i), 3'd7, 22'(4 * i)));
        for (i = 0; i < 7; i++) sendInstr(memOpWord(4'd15, 3'(i), 3'd7, {3'(6 - i), 19'd0}));
        finishTest("load and store addressing");

        for (i = 0; i < 16; i++) begin // alternate add and bitwise
            word = aluWord(4'(i % 2), 3'($urandom % 7), 3'($urandom % 8), 1'($urandom),
                1'($urandom), 3'($urandom % 8), 16'($urandom));
            sendInstr(word);
            sendInstr(memOpWord(4'd14, word[27:25], 3'd7, 22'(i)));
        end
        finishTest("add subtract bitwise");

        for (i = 0; i < 13; i++) begin
            code = (i < 6) ? 4'(i) : (i < 12) ? 4'(i + 2) : 4'd6; // last one passes through
            sendInstr(aluWord(4'd3, 3'd2, 3'd1, code[3], code[2], {code[1:0], 1'b0}, 16'd0));
            sendInstr(memOpWord(4'd14, 3'd2, 3'd7, 22'(i)));
        end
        finishTest("shift table");

        incR1 = aluWord(4'd0, 3'd1, 3'd1, 1'b1, 1'b0, 3'd0, 16'd1); // r1 = r1 + 1
        sendInstr(aluWord(4'd0, 3'd0, 3'd7, 1'b0, 1'b1, 3'd7, 16'd0)); // r0 = 0
        sendInstr(aluWord(4'd0, 3'd0, 3'd0, 1'b1, 1'b0, 3'd0, 16'd5)); // r0 = 5
        sendInstr(cmpWord(4'd4, 3'b101, 6'd3, 3'd0, 16'd5)); // equal so skip 3
        sendInstr(incR1);
        sendInstr(memOpWord(4'd14, 3'd1, 3'd7, 22'h40)); // skipped store
        sendInstr(incR1);
        sendInstr(incR1); // first one that runs
        sendInstr(memOpWord(4'd14, 3'd1, 3'd7, 22'h41));
        sendInstr(cmpWord(4'd5, 3'b010, 6'd4, 3'd0, 16'd0)); // zero class masked so no skip
        sendInstr(incR1);
        sendInstr(memOpWord(4'd14, 3'd1, 3'd7, 22'h42));
        sendInstr(cmpWord(4'd4, 3'b110, 6'd2, 3'd0, 16'd7)); // 5 - 7 is negative so skip 2
        sendInstr(incR1);
        sendInstr(incR1);
        sendInstr(memOpWord(4'd14, 3'd1, 3'd7, 22'h43));
        finishTest("compare and skip");

        readSnap = readCycles;
        writeSnap = writeCycles;
        sendInstr({4'd2, 28'($urandom)}); // multiply
        sendInstr({4'd8, 28'($urandom)}); // scratchpad ops
        sendInstr({4'd9, 28'($urandom)});
        sendInstr({4'd12, 28'($urandom)});
        sendInstr({4'd13, 28'($urandom)});
        waitReady("after the dropped opcodes");
        assert (readCycles == readSnap && writeCycles == writeSnap) else begin
            $display("a dropped opcode raised reading or writing");
            errorCount++;
        end
        for (i = 0; i < 7; i++) sendInstr(memOpWord(4'd14, 3'(i), 3'd7, 22'(8 * i)));
        finishTest("dropped opcodes");

        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: compile.f
gpuCorePkg.sv
coreDecoder.sv
registerFile.sv
aluExecute.sv
resultPath.sv
gpuCore.sv
gpuCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the gpuCore testbench with Verilator
set -e -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module gpuCoreTb \
    -f compile.f -o gpuCoreSim
./obj_dir/gpuCoreSim | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "run.sh: testbench reported failure"
    exit 1
fi
echo "run.sh: testbench passed"
